/* depth_pkg.sv */
package depth_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry and stream constants

    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 12;

    // "BIVFRAME", sent most significant byte first
    localparam logic [63:0] MAGIC_NUM   = 64'h4249_5646_5241_4d45;
    localparam int          MAGIC_BYTES = 8;

    // host command framing
    localparam int          CMD_BYTES      = 6;
    localparam logic [15:0] REG_CONFIDENCE = 16'h0001;

    localparam int PIXEL_FIFO_DEPTH = 32;

    ////////////////////////////////////////////////////////////////////////////
    // shared types

    // raw half-precision bits
    typedef logic [15:0] fp16_t;

    // all-ones mantissa, exponent saturates the converter
    localparam fp16_t DEPTH_SATURATED = 16'h7fff;

    typedef struct packed {
        logic       valid;
        logic       sof;
        logic [7:0] raw;
        fp16_t      z;
        fp16_t      c;
    } pixel_beat_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } host_cmd_t;

    typedef struct packed {
        logic       valid;
        logic       frame_start;
        logic [7:0] col;
        logic [7:0] row;
        logic [7:0] raw;
        fp16_t      z;
        fp16_t      c;
    } positioned_pixel_t;

    typedef struct packed {
        logic       valid;
        logic       frame_start;
        logic [7:0] raw;
        logic [7:0] depth;
    } depth_pixel_t;

endpackage

/* host_command_decoder.sv */
module host_command_decoder (
    input  logic              core_clk,
    input  logic              sys_reset,
    input  logic [7:0]        host_byte_i,
    input  logic              host_byte_valid_i,
    output depth_pkg::fp16_t  confidence_o
);
    import depth_pkg::*;

    // first byte ends up in the top of the word
    logic [39:0] shift_q;
    logic [2:0]  byte_cnt_q;
    logic        last_byte;
    host_cmd_t   cmd;

    assign last_byte = host_byte_valid_i && (byte_cnt_q == 3'(CMD_BYTES - 1));

    // complete command including the byte arriving now
    assign cmd = host_cmd_t'({shift_q, host_byte_i});

    ////////////////////////////////////////////////////////////////////////////
    // byte assembly

    always_ff @(posedge core_clk) begin
        if (host_byte_valid_i) begin
            shift_q <= {shift_q[31:0], host_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q <= '0;
        end else if (last_byte) begin
            byte_cnt_q <= '0;
        end else if (host_byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 3'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file, only the threshold is kept here

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            confidence_o <= '0;
        end else if (last_byte && (cmd.addr == REG_CONFIDENCE)) begin
            // threshold lives in the low half of the data word
            confidence_o <= cmd.data[15:0];
        end
    end

endmodule

/* pixel_position_tracker.sv */
module pixel_position_tracker (
    input  logic                          core_clk,
    input  logic                          sys_reset,
    input  depth_pkg::pixel_beat_t        pixel_i,
    output depth_pkg::positioned_pixel_t  pixel_o
);
    import depth_pkg::*;

    // position that the next valid beat will take
    logic [7:0] col_q;
    logic [7:0] row_q;
    logic [7:0] cur_col;
    logic [7:0] cur_row;

    logic        valid_q;
    logic        frame_start_q;
    logic [7:0]  col_out_q;
    logic [7:0]  row_out_q;
    logic [7:0]  raw_q;
    fp16_t       z_q;
    fp16_t       c_q;

    // sof forces the beat back to the frame origin
    assign cur_col = pixel_i.sof ? 8'd0 : col_q;
    assign cur_row = pixel_i.sof ? 8'd0 : row_q;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pixel_i.valid) begin
            if (cur_col == 8'(FRAME_WIDTH - 1)) begin
                col_q <= '0;
                row_q <= (cur_row == 8'(FRAME_HEIGHT - 1)) ? 8'd0 : cur_row + 8'd1;
            end else begin
                col_q <= cur_col + 8'd1;
                row_q <= cur_row;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            valid_q       <= 1'b0;
            frame_start_q <= 1'b0;
        end else begin
            valid_q       <= pixel_i.valid;
            frame_start_q <= pixel_i.valid && (cur_col == 8'd0) && (cur_row == 8'd0);
        end
    end

    // payload
    always_ff @(posedge core_clk) begin
        col_out_q <= cur_col;
        row_out_q <= cur_row;
        raw_q     <= pixel_i.raw;
        z_q       <= pixel_i.z;
        c_q       <= pixel_i.c;
    end

    assign pixel_o = '{valid: valid_q, frame_start: frame_start_q, col: col_out_q,
                       row: row_out_q, raw: raw_q, z: z_q, c: c_q};

endmodule

/* depth_confidence_stage.sv */
module depth_confidence_stage (
    input  logic                          core_clk,
    input  logic                          sys_reset,
    input  depth_pkg::positioned_pixel_t  pixel_i,
    input  depth_pkg::fp16_t              confidence_i,
    output depth_pkg::depth_pixel_t       pixel_o
);
    import depth_pkg::*;

    fp16_t       depth_sel;
    logic [4:0]  exp_biased;
    logic [10:0] significand;
    logic [10:0] sig_shifted;
    logic [7:0]  depth_u8;

    logic        valid_q;
    logic        frame_start_q;
    logic [7:0]  raw_q;
    logic [7:0]  depth_q;

    ////////////////////////////////////////////////////////////////////////////
    // confidence filter
    // plain unsigned compare, good enough for non-negative fp16

    assign depth_sel = (pixel_i.c >= confidence_i) ? pixel_i.z : DEPTH_SATURATED;

    ////////////////////////////////////////////////////////////////////////////
    // fp16 to u8, lead exponent of -1
    // 0.5 lands on 128, anything from 1.0 up saturates

    assign exp_biased  = depth_sel[14:10];
    assign significand = {1'b1, depth_sel[9:0]};
    assign sig_shifted = significand >> (5'd17 - exp_biased);

    always_comb begin
        if (depth_sel[15]) begin
            depth_u8 = 8'd0;
        end else if (exp_biased >= 5'd15) begin
            depth_u8 = 8'd255;
        end else if (exp_biased == 5'd0) begin
            // subnormals are below one lsb
            depth_u8 = 8'd0;
        end else begin
            depth_u8 = sig_shifted[7:0];
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            valid_q       <= 1'b0;
            frame_start_q <= 1'b0;
        end else begin
            valid_q       <= pixel_i.valid;
            frame_start_q <= pixel_i.valid && pixel_i.frame_start;
        end
    end

    always_ff @(posedge core_clk) begin
        raw_q   <= pixel_i.raw;
        depth_q <= depth_u8;
    end

    assign pixel_o = '{valid: valid_q, frame_start: frame_start_q,
                       raw: raw_q, depth: depth_q};

endmodule

/* frame_byte_serializer.sv */
module frame_byte_serializer (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  depth_pkg::depth_pixel_t  pixel_i,
    input  logic                     host_stall_i,
    output logic [7:0]               byte_o,
    output logic                     byte_valid_o,
    output logic                     overflow_o
);
    import depth_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // pixel FIFO

    depth_pixel_t mem [PIXEL_FIFO_DEPTH];

    // one extra bit tells full from empty
    logic [$clog2(PIXEL_FIFO_DEPTH):0]   wr_ptr_q;
    logic [$clog2(PIXEL_FIFO_DEPTH):0]   rd_ptr_q;
    logic [$clog2(PIXEL_FIFO_DEPTH):0]   fill;
    logic                                fifo_empty;
    logic                                fifo_full;
    logic                                push;
    logic                                pop;
    depth_pixel_t                        head;

    assign fill       = wr_ptr_q - rd_ptr_q;
    assign fifo_empty = (fill == '0);
    assign fifo_full  = (fill == ($clog2(PIXEL_FIFO_DEPTH) + 1)'(PIXEL_FIFO_DEPTH));
    assign push       = pixel_i.valid && !fifo_full;
    assign head       = mem[rd_ptr_q[$clog2(PIXEL_FIFO_DEPTH)-1:0]];

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr_q[$clog2(PIXEL_FIFO_DEPTH)-1:0]] <= pixel_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // pixel is lost, flag stays up until reset
            if (pixel_i.valid && fifo_full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output sequencer
    // header (frame starts only), then raw, then depth per entry

    logic [$clog2(MAGIC_BYTES)-1:0] hdr_idx_q;
    logic                           hdr_done_q;
    logic                           depth_phase_q;
    logic                           emit_header;
    logic [7:0]                     magic_byte;

    assign emit_header  = head.frame_start && !hdr_done_q;
    assign magic_byte   = MAGIC_NUM[63 - 8 * hdr_idx_q -: 8];
    assign byte_valid_o = !fifo_empty && !host_stall_i;
    assign pop          = byte_valid_o && !emit_header && depth_phase_q;

    always_comb begin
        if (emit_header) begin
            byte_o = magic_byte;
        end else if (depth_phase_q) begin
            byte_o = head.depth;
        end else begin
            byte_o = head.raw;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            hdr_idx_q     <= '0;
            hdr_done_q    <= 1'b0;
            depth_phase_q <= 1'b0;
        end else if (byte_valid_o) begin
            if (emit_header) begin
                if (hdr_idx_q == ($clog2(MAGIC_BYTES))'(MAGIC_BYTES - 1)) begin
                    hdr_idx_q  <= '0;
                    hdr_done_q <= 1'b1;
                end else begin
                    hdr_idx_q <= hdr_idx_q + 1'b1;
                end
            end else if (!depth_phase_q) begin
                depth_phase_q <= 1'b1;
            end else begin
                // entry retired, next head starts clean
                depth_phase_q <= 1'b0;
                hdr_done_q    <= 1'b0;
            end
        end
    end

endmodule

/* depth_preview_top.sv */
module depth_preview_top (
    input  logic                    core_clk,
    input  logic                    sys_reset,

    // pixel stream, valid at most every other cycle
    input  depth_pkg::pixel_beat_t  pixel_i,

    // host command bytes
    input  logic [7:0]              host_byte_i,
    input  logic                    host_byte_valid_i,

    // byte stream to host
    input  logic                    host_stall_i,
    output logic [7:0]              byte_o,
    output logic                    byte_valid_o,
    output logic                    overflow_o
);
    import depth_pkg::*;

    fp16_t             confidence;
    positioned_pixel_t positioned_pixel;
    depth_pixel_t      depth_pixel;

    host_command_decoder u_host_command_decoder (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i),
        .confidence_o      (confidence)
    );

    pixel_position_tracker u_pixel_position_tracker (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .pixel_i   (pixel_i),
        .pixel_o   (positioned_pixel)
    );

    depth_confidence_stage u_depth_confidence_stage (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pixel_i      (positioned_pixel),
        .confidence_i (confidence),
        .pixel_o      (depth_pixel)
    );

    frame_byte_serializer u_frame_byte_serializer (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pixel_i      (depth_pixel),
        .host_stall_i (host_stall_i),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o),
        .overflow_o   (overflow_o)
    );

endmodule

/* depth_preview_asserts.sv */
module depth_preview_asserts (
    input logic core_clk,
    input logic sys_reset,
    input logic host_stall_i,
    input logic byte_valid_o,
    input logic overflow_o
);

    // a stalled host is never offered a byte
    stall_blocks_byte: assert property (
        @(posedge core_clk) disable iff (sys_reset) host_stall_i |-> !byte_valid_o
    ) else $error("byte_valid_o high while host_stall_i is high");

    // pixel rate stays below the drain rate
    overflow_stays_low: assert property (
        @(posedge core_clk) disable iff (sys_reset) !$rose(overflow_o)
    ) else $error("overflow_o rose, a pixel was dropped");

    // second reset cycle onward, state is already cleared
    quiet_in_reset: assert property (
        @(posedge core_clk) (sys_reset && $past(sys_reset)) |-> !byte_valid_o
    ) else $error("byte_valid_o high during reset");

endmodule

/* depth_preview_tb.sv */
module depth_preview_tb;
    import depth_pkg::*;

    localparam int NUM_ROWS   = 20;
    localparam int NUM_PASSES = 20;
    localparam int CLK_PERIOD = 100;
    // four-cycle slot per row plus at most one command, three times over, plus margin
    localparam int WATCHDOG_CYCLES = NUM_ROWS * NUM_PASSES * (4 + CMD_BYTES) * 3 + 500;

    typedef struct packed {
        logic        cmd_en;
        logic [15:0] cmd_addr;
        logic [31:0] cmd_data;
        logic        sof;
        logic [7:0]  raw;
        fp16_t       z;
        fp16_t       c;
    } stim_row_t;

    // kind 0 header, 1 raw, 2 depth
    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] value;
    } exp_byte_t;

    logic        core_clk;
    logic        sys_reset;
    pixel_beat_t pixel_i;
    logic [7:0]  host_byte_i;
    logic        host_byte_valid_i;
    logic        host_stall_i;
    logic [7:0]  byte_o;
    logic        byte_valid_o;
    logic        overflow_o;

    stim_row_t   stim [NUM_ROWS];
    exp_byte_t   exp_q [$];
    int          model_col;
    int          model_row;
    fp16_t       model_thresh;
    int          mismatch_count;
    int          sequence_errors;
    int          bytes_checked;
    int          cycle_count;

    depth_preview_top u_depth_preview_top (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .pixel_i           (pixel_i),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i),
        .host_stall_i      (host_stall_i),
        .byte_o            (byte_o),
        .byte_valid_o      (byte_valid_o),
        .overflow_o        (overflow_o)
    );

    bind depth_preview_top depth_preview_asserts u_depth_preview_asserts (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .host_stall_i (host_stall_i),
        .byte_valid_o (byte_valid_o),
        .overflow_o   (overflow_o)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("timeout after %0d cycles, %0d bytes never arrived",
                 WATCHDOG_CYCLES, exp_q.size());
        report_counts();
        $display("Some tests failed");
        $finish;
    end

    // host stalls on about a quarter of the cycles
    initial begin
        void'($urandom(32'h94c1_94f2));
        forever begin
            @(posedge core_clk);
            #5;
            host_stall_i = ($urandom % 4) == 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor, bytes are taken at the rising edge

    always @(posedge core_clk) begin
        exp_byte_t e;
        if (sys_reset) begin
            if (cycle_count > 0) begin
                check_flag("byte_valid_o", byte_valid_o, 1'b0);
                check_flag("overflow_o", overflow_o, 1'b0);
            end
        end else begin
            check_flag("overflow_o", overflow_o, 1'b0);
            if (host_stall_i) begin
                check_flag("byte_valid_o", byte_valid_o, 1'b0);
            end
            if (byte_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("extra byte 0x%h delivered at %0t with nothing expected",
                             byte_o, $time);
                    sequence_errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_byte(byte_kind_name(e.kind), byte_o, e.value);
                    bytes_checked++;
                end
            end
        end
        cycle_count++;
    end

    function automatic string byte_kind_name(input logic [1:0] kind);
        if (kind == 2'd0) begin
            return "byte_o(header)";
        end else if (kind == 2'd1) begin
            return "byte_o(raw)";
        end
        return "byte_o(depth)";
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic report_counts();
        $display("checked %0d bytes: %0d mismatches, %0d missing or extra bytes",
                 bytes_checked, mismatch_count, sequence_errors + exp_q.size());
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // value times 256, floored, saturating at 1.0
    function automatic logic [7:0] fp16_to_u8_ref(input fp16_t h);
        int e;
        int sig;
        e   = int'(h[14:10]);
        sig = 1024 + int'(h[9:0]);
        if (h[15] || e == 0) begin
            return 8'd0;
        end
        if (e >= 15) begin
            return 8'd255;
        end
        return 8'(sig / (1 << (17 - e)));
    endfunction

    task automatic expect_byte(input logic [1:0] kind, input logic [7:0] value);
        exp_byte_t e;
        e.kind  = kind;
        e.value = value;
        exp_q.push_back(e);
    endtask

    task automatic push_expected(input logic sof, input logic [7:0] raw,
                                 input fp16_t z, input fp16_t c);
        int i;
        if (sof) begin
            model_col = 0;
            model_row = 0;
        end
        if (model_col == 0 && model_row == 0) begin
            for (i = 0; i < MAGIC_BYTES; i++) begin
                expect_byte(2'd0, MAGIC_NUM[63 - 8 * i -: 8]);
            end
        end
        expect_byte(2'd1, raw);
        expect_byte(2'd2, fp16_to_u8_ref((c < model_thresh) ? DEPTH_SATURATED : z));
        model_col++;
        if (model_col == FRAME_WIDTH) begin
            model_col = 0;
            model_row++;
            if (model_row == FRAME_HEIGHT) begin
                model_row = 0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus drivers

    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        host_cmd_t cmd;
        int        i;
        cmd.addr = addr;
        cmd.data = data;
        for (i = 0; i < CMD_BYTES; i++) begin
            @(posedge core_clk);
            #5;
            host_byte_i       = cmd[47 - 8 * i -: 8];
            host_byte_valid_i = 1'b1;
        end
        @(posedge core_clk);
        #5;
        host_byte_valid_i = 1'b0;
        if (addr == REG_CONFIDENCE) begin
            model_thresh = data[15:0];
        end
    endtask

    // one pixel per four cycles
    task automatic drive_pixel(input logic sof, input logic [7:0] raw,
                               input fp16_t z, input fp16_t c);
        @(posedge core_clk);
        #5;
        pixel_i = '{valid: 1'b1, sof: sof, raw: raw, z: z, c: c};
        push_expected(sof, raw, z, c);
        @(posedge core_clk);
        #5;
        pixel_i.valid = 1'b0;
        pixel_i.sof   = 1'b0;
        repeat (2) @(posedge core_clk);
    endtask

    initial begin
        int   pass;
        int   r;
        logic sof_eff;
        sys_reset         = 1'b1;
        pixel_i           = '0;
        host_byte_i       = '0;
        host_byte_valid_i = 1'b0;
        host_stall_i      = 1'b0;
        model_col         = 0;
        model_row         = 0;
        model_thresh      = '0;
        mismatch_count    = 0;
        sequence_errors   = 0;
        bytes_checked     = 0;
        cycle_count       = 0;

        // cmd_en, cmd_addr, cmd_data, sof, raw, z, c
        stim = '{
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b1, 8'h11, 16'h3800, 16'h3c00},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h22, 16'hb800, 16'h3c00},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h33, 16'h3c00, 16'h0000},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h44, 16'h0123, 16'h0000},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h55, 16'h3555, 16'h1000},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h66, 16'h2e66, 16'h2000},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h77, 16'h7c00, 16'h0400},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h88, 16'h1400, 16'h3000},
            '{1'b1, 16'h0001, 32'hdead_3800, 1'b0, 8'h99, 16'h3400, 16'h3000},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'haa, 16'h3400, 16'h3800},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'hbb, 16'h3b00, 16'h3a00},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'hcc, 16'h3800, 16'h0000},
            '{1'b1, 16'h0002, 32'h0000_ffff, 1'b0, 8'hdd, 16'h3000, 16'h3400},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'hee, 16'h3000, 16'h3c00},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'hf0, 16'h3200, 16'h37ff},
            '{1'b1, 16'h0001, 32'h0000_0000, 1'b0, 8'h01, 16'h3200, 16'h0000},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h02, 16'h3666, 16'h1234},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h03, 16'h2800, 16'h5555},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h04, 16'h39a0, 16'h0001},
            '{1'b0, 16'h0000, 32'h0000_0000, 1'b0, 8'h05, 16'h3bff, 16'h7bff}
        };

        repeat (10) @(posedge core_clk);
        #5;
        sys_reset = 1'b0;

        // sof on the first pass and again mid-frame halfway through,
        // the run is long enough to see the next frame after that one
        for (pass = 0; pass < NUM_PASSES; pass++) begin
            for (r = 0; r < NUM_ROWS; r++) begin
                if (stim[r].cmd_en) begin
                    send_command(stim[r].cmd_addr, stim[r].cmd_data);
                end
                sof_eff = stim[r].sof && (pass == 0 || pass == NUM_PASSES / 2);
                drive_pixel(sof_eff, 8'(stim[r].raw + pass), stim[r].z, stim[r].c);
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge core_clk);
        end
        // idle tail catches stray bytes
        repeat (20) @(posedge core_clk);

        report_counts();
        if (mismatch_count == 0 && sequence_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
depth_pkg.sv
host_command_decoder.sv
pixel_position_tracker.sv
depth_confidence_stage.sv
frame_byte_serializer.sv
depth_preview_top.sv
depth_preview_asserts.sv
depth_preview_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the depth previewer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module depth_preview_tb -o depth_preview_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/depth_preview_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
